// ==== logic/rv_macros.svh ====
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// data and address width
`define RV_XLEN 32

// register file geometry
`define RV_REG_AW 5
`define RV_NUM_REGS 32

// bubble contents, addi x0,x0,0 at pc zero
`define RV_NOP_IR 32'h0000_0013
`define RV_NOP_PC 32'h0000_0000

`endif

// ==== logic/rv_isa_pkg.sv ====
`default_nettype none

`include "rv_macros.svh"

package rv_isa_pkg;

typedef logic [`RV_XLEN-1:0]   word_t;
typedef logic [`RV_REG_AW-1:0] regaddr_t;

// major opcodes, bits 6:0 of the instruction
typedef enum logic [6:0] {
    OP_LOAD     = 7'b000_0011,
    OP_MISC_MEM = 7'b000_1111,
    OP_IMM      = 7'b001_0011,
    OP_AUIPC    = 7'b001_0111,
    OP_STORE    = 7'b010_0011,
    OP          = 7'b011_0011,
    OP_LUI      = 7'b011_0111,
    OP_BRANCH   = 7'b110_0011,
    OP_JALR     = 7'b110_0111,
    OP_JAL      = 7'b110_1111,
    OP_SYSTEM   = 7'b111_0011
} opcode_t;

// branch conditions, bit 0 inverts the compare
typedef enum logic [2:0] {
    F3_BEQ  = 3'b000,
    F3_BNE  = 3'b001,
    F3_BLT  = 3'b100,
    F3_BGE  = 3'b101,
    F3_BLTU = 3'b110,
    F3_BGEU = 3'b111
} funct3_t;

// {funct7[0], funct7[5], funct3}
typedef enum logic [4:0] {
    ALU_ADD    = 5'b00000,
    ALU_SLL    = 5'b00001,
    ALU_SLT    = 5'b00010,
    ALU_SLTU   = 5'b00011,
    ALU_XOR    = 5'b00100,
    ALU_SRL    = 5'b00101,
    ALU_OR     = 5'b00110,
    ALU_AND    = 5'b00111,
    ALU_SUB    = 5'b01000,
    ALU_SRA    = 5'b01101,
    ALU_MUL    = 5'b10000,
    ALU_MULH   = 5'b10001,
    ALU_MULHSU = 5'b10010,
    ALU_MULHU  = 5'b10011,
    ALU_DIV    = 5'b10100,
    ALU_DIVU   = 5'b10101,
    ALU_REM    = 5'b10110,
    ALU_REMU   = 5'b10111
} alu_mode_t;

typedef enum logic [1:0] {
    MA_X     = 2'b00, // no memory access
    MA_LOAD  = 2'b01,
    MA_STORE = 2'b10
} ma_mode_t;

typedef logic [2:0] ma_size_t; // funct3 of the load or store
localparam ma_size_t MA_SIZE_W = 3'b010;

typedef enum logic [1:0] {
    WB_SRC_X   = 2'b00, // nothing written back
    WB_SRC_ALU = 2'b01,
    WB_SRC_MEM = 2'b10,
    WB_SRC_PC4 = 2'b11
} wb_src_t;

endpackage

`default_nettype wire

// ==== logic/id_pipe_pkg.sv ====
`default_nettype none

package id_pipe_pkg;

import rv_isa_pkg::*;

typedef enum logic [1:0] {
    PC_NEXT,
    PC_JUMP_REL, // pc + J immediate
    PC_JUMP_ABS, // rs1 + I immediate
    PC_BRANCH
} pc_mode_t;

typedef enum logic [1:0] {
    OP1_ZERO,
    OP1_RS1,
    OP1_IMMU
} alu_op1_t;

typedef enum logic [2:0] {
    OP2_ZERO,
    OP2_RS2,
    OP2_IMMI,
    OP2_IMMS,
    OP2_PC
} alu_op2_t;

typedef struct packed {
    word_t pc;
    word_t ir;
} if_id_t;

// result bundle of a later stage
typedef struct packed {
    logic     valid; // instruction will write addr
    regaddr_t addr;
    word_t    data;
    logic     ready; // data is final
} fwd_t;

typedef struct packed {
    logic      halt;
    pc_mode_t  pc_mode;
    alu_op1_t  alu_op1;
    alu_op2_t  alu_op2;
    alu_mode_t alu_mode;
    ma_mode_t  ma_mode;
    ma_size_t  ma_size;
    wb_src_t   wb_src;
} ctrl_word_t;

typedef struct packed {
    ctrl_word_t cw;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    funct3_t    f3;
    regaddr_t   rd;
} dec_t;

typedef struct packed {
    regaddr_t addr;
    logic     used; // read by the instruction and not x0
} src_req_t;

typedef struct packed {
    word_t     pc;
    word_t     ir;
    word_t     alu_op1;
    word_t     alu_op2;
    alu_mode_t alu_mode;
    ma_mode_t  ma_mode;
    ma_size_t  ma_size;
    word_t     ma_data;
    wb_src_t   wb_src;
    word_t     wb_data;
    logic      wb_valid;
    logic      halt;
} id_ex_t;

endpackage

`default_nettype wire

// ==== logic/id_decoder.sv ====
`default_nettype none

module id_decoder
    import rv_isa_pkg::*;
    import id_pipe_pkg::*;
(
    input  wire if_id_t         instr_i, // word presented by fetch
    output      dec_t           dec_o,
    output      src_req_t [1:0] src_o    // rs1 at 0, rs2 at 1
);

word_t      ir_w;
logic [6:0] f7_w;
regaddr_t   rs2_w;
regaddr_t   rs1_w;
logic [2:0] f3_w;
regaddr_t   rd_w;
logic [6:0] op_w;
alu_mode_t  mode3_w;
alu_mode_t  mode7_w;
ctrl_word_t cw_w;
logic       rs1_read_w;
logic       rs2_read_w;

always_comb begin
    ir_w = instr_i.ir;
    {f7_w, rs2_w, rs1_w, f3_w, rd_w, op_w} = ir_w;
    mode7_w = alu_mode_t'({f7_w[0], f7_w[5], f3_w});
    mode3_w = alu_mode_t'({2'b00, f3_w}); // immediate forms ignore funct7
end

always_comb begin
    dec_o.cw    = cw_w;
    dec_o.imm_i = {{21{ir_w[31]}}, ir_w[30:20]};
    dec_o.imm_s = {{21{ir_w[31]}}, ir_w[30:25], ir_w[11:7]};
    dec_o.imm_b = {{20{ir_w[31]}}, ir_w[7], ir_w[30:25], ir_w[11:8], 1'b0};
    dec_o.imm_u = {ir_w[31:12], 12'b0};
    dec_o.imm_j = {{12{ir_w[31]}}, ir_w[19:12], ir_w[20], ir_w[30:21], 1'b0};
    dec_o.f3    = funct3_t'(f3_w);
    dec_o.rd    = rd_w;
end

// first matching row wins
always_comb begin
    casez ({f7_w, f3_w, op_w})
    {7'b0?00000, 3'b101, OP_IMM}:    // srli and srai
        cw_w = '{1'b0, PC_NEXT, OP1_RS1, OP2_IMMI, mode7_w, MA_X, MA_SIZE_W, WB_SRC_ALU};
    {7'b???????, 3'b???, OP_IMM}:
        cw_w = '{1'b0, PC_NEXT, OP1_RS1, OP2_IMMI, mode3_w, MA_X, MA_SIZE_W, WB_SRC_ALU};
    {7'b???????, 3'b???, OP_LUI}:
        cw_w = '{1'b0, PC_NEXT, OP1_IMMU, OP2_ZERO, ALU_ADD, MA_X, MA_SIZE_W, WB_SRC_ALU};
    {7'b???????, 3'b???, OP_AUIPC}:
        cw_w = '{1'b0, PC_NEXT, OP1_IMMU, OP2_PC, ALU_ADD, MA_X, MA_SIZE_W, WB_SRC_ALU};
    {7'b0?00000, 3'b000, OP},        // add and sub
    {7'b0?00000, 3'b101, OP},        // srl and sra
    {7'b0000000, 3'b???, OP},
    {7'b0000001, 3'b???, OP}:        // multiply and divide
        cw_w = '{1'b0, PC_NEXT, OP1_RS1, OP2_RS2, mode7_w, MA_X, MA_SIZE_W, WB_SRC_ALU};
    {7'b???????, 3'b???, OP_JAL}:
        cw_w = '{1'b0, PC_JUMP_REL, OP1_ZERO, OP2_ZERO, ALU_ADD, MA_X, MA_SIZE_W, WB_SRC_PC4};
    {7'b???????, 3'b000, OP_JALR}:
        cw_w = '{1'b0, PC_JUMP_ABS, OP1_ZERO, OP2_ZERO, ALU_ADD, MA_X, MA_SIZE_W, WB_SRC_PC4};
    {7'b???????, 3'b00?, OP_BRANCH}, // beq and bne
    {7'b???????, 3'b1??, OP_BRANCH}:
        cw_w = '{1'b0, PC_BRANCH, OP1_ZERO, OP2_ZERO, ALU_ADD, MA_X, MA_SIZE_W, WB_SRC_X};
    {7'b???????, 3'b???, OP_LOAD}:
        cw_w = '{1'b0, PC_NEXT, OP1_RS1, OP2_IMMI, ALU_ADD, MA_LOAD, f3_w, WB_SRC_MEM};
    {7'b???????, 3'b???, OP_STORE}:
        cw_w = '{1'b0, PC_NEXT, OP1_RS1, OP2_IMMS, ALU_ADD, MA_STORE, f3_w, WB_SRC_X};
    {7'b???????, 3'b???, OP_MISC_MEM}: // fences pass as nop
        cw_w = '{1'b0, PC_NEXT, OP1_ZERO, OP2_ZERO, ALU_ADD, MA_X, MA_SIZE_W, WB_SRC_X};
    default:                         // unknown and system words stop the core
        cw_w = '{1'b1, PC_NEXT, OP1_ZERO, OP2_ZERO, ALU_ADD, MA_X, MA_SIZE_W, WB_SRC_X};
    endcase
end

// operand reads follow from the selected datapath
always_comb begin
    rs1_read_w = (cw_w.alu_op1 == OP1_RS1) || (cw_w.pc_mode inside {PC_JUMP_ABS, PC_BRANCH});
    rs2_read_w = (cw_w.alu_op2 == OP2_RS2) || (cw_w.ma_mode == MA_STORE)
                 || (cw_w.pc_mode == PC_BRANCH);

    src_o[0].addr = rs1_w;
    src_o[0].used = rs1_read_w && (rs1_w != '0); // x0 never waits
    src_o[1].addr = rs2_w;
    src_o[1].used = rs2_read_w && (rs2_w != '0);
end

// a halting word must never claim a register write in EX
always_comb begin
    assert final (!cw_w.halt || (cw_w.wb_src == WB_SRC_X))
        else $error("halt decoded with a write-back source");
end

endmodule

`default_nettype wire

// ==== logic/id_regfile.sv ====
`default_nettype none

`include "rv_macros.svh"

module id_regfile
    import rv_isa_pkg::*;
    import id_pipe_pkg::*;
(
    input  wire logic           clk_i,
    input  wire regaddr_t [1:0] rd_addr_i,
    output      word_t    [1:0] rd_data_o,
    input  wire fwd_t           wr_i       // write-back stage result
);

word_t regs_r [`RV_NUM_REGS];

always_ff @(posedge clk_i) begin
    if (wr_i.valid) begin
        regs_r[wr_i.addr] <= wr_i.data;
    end
end

always_comb begin
    for (int i = 0; i < 2; i++) begin
        rd_data_o[i] = (rd_addr_i[i] == '0) ? '0 : regs_r[rd_addr_i[i]]; // x0 reads as zero
    end
end

// producers drop writes to x0 before they reach write-back
assert property (@(posedge clk_i) wr_i.valid |-> (wr_i.addr != '0))
    else $error("register file write to x0");

endmodule

`default_nettype wire

// ==== logic/id_operand_fwd.sv ====
`default_nettype none

module id_operand_fwd
    import rv_isa_pkg::*;
    import id_pipe_pkg::*;
(
    input  wire src_req_t req_i,
    input  wire word_t    rf_data_i, // register file value for req_i.addr
    input  wire fwd_t     ex_fwd_i,
    input  wire fwd_t     ma_fwd_i,
    input  wire fwd_t     wb_fwd_i,  // ready bit not used here
    output      word_t    value_o,
    output      logic     hazard_o
);

logic ex_hit_w;
logic ma_hit_w;
logic wb_hit_w;

always_comb begin
    ex_hit_w = ex_fwd_i.valid && (ex_fwd_i.addr == req_i.addr);
    ma_hit_w = ma_fwd_i.valid && (ma_fwd_i.addr == req_i.addr);
    wb_hit_w = wb_fwd_i.valid && (wb_fwd_i.addr == req_i.addr);
end

// youngest producer wins
always_comb begin
    if (ex_hit_w) begin
        value_o = ex_fwd_i.data;
    end else if (ma_hit_w) begin
        value_o = ma_fwd_i.data;
    end else if (wb_hit_w) begin
        value_o = wb_fwd_i.data;
    end else begin
        value_o = rf_data_i;
    end
end

// wait while a matching EX or MA result is still in flight
always_comb begin
    hazard_o = req_i.used && ((ex_hit_w && !ex_fwd_i.ready) || (ma_hit_w && !ma_fwd_i.ready));
end

endmodule

`default_nettype wire

// ==== logic/id_issue.sv ====
`default_nettype none

`include "rv_macros.svh"

module id_issue
    import rv_isa_pkg::*;
    import id_pipe_pkg::*;
(
    input  wire logic        clk_i,
    input  wire logic        reset_i,
    input  wire if_id_t      instr_i,
    input  wire dec_t        dec_i,
    input  wire word_t [1:0] op_value_i, // bypassed rs1 and rs2
    input  wire logic  [1:0] hazard_i,
    output      logic        ready_o,
    output      logic        jmp_valid_o,
    output      word_t       jmp_addr_o,
    output      id_ex_t      id_ex_o
);

localparam id_ex_t NOP_ID_EX = '{
    pc:       `RV_NOP_PC,
    ir:       `RV_NOP_IR,
    alu_op1:  '0,
    alu_op2:  '0,
    alu_mode: ALU_ADD,
    ma_mode:  MA_X,
    ma_size:  MA_SIZE_W,
    ma_data:  '0,
    wb_src:   WB_SRC_X,
    wb_data:  '0,
    wb_valid: 1'b0,
    halt:     1'b0
};

word_t  rs1_w;
word_t  rs2_w;
logic   hazard_w;
logic   cond_w;
logic   taken_w;
id_ex_t next_w;

always_comb begin
    rs1_w    = op_value_i[0];
    rs2_w    = op_value_i[1];
    hazard_w = |hazard_i;
    ready_o  = !hazard_w; // fetch holds the word while waiting
end

always_comb begin
    case (dec_i.f3[2:1])
    2'b00:   cond_w = (rs1_w == rs2_w);
    2'b10:   cond_w = ($signed(rs1_w) < $signed(rs2_w));
    2'b11:   cond_w = (rs1_w < rs2_w);
    default: cond_w = 1'b0; // not a branch condition
    endcase
    taken_w = cond_w ^ dec_i.f3[0];
end

always_comb begin
    case (dec_i.cw.pc_mode)
    PC_JUMP_REL: begin
        jmp_valid_o = 1'b1; // jal needs no registers
        jmp_addr_o  = instr_i.pc + dec_i.imm_j;
    end
    PC_JUMP_ABS: begin
        jmp_valid_o = !hazard_w;
        jmp_addr_o  = rs1_w + dec_i.imm_i;
    end
    PC_BRANCH: begin
        jmp_valid_o = taken_w && !hazard_w;
        jmp_addr_o  = instr_i.pc + dec_i.imm_b;
    end
    default: begin
        jmp_valid_o = 1'b0;
        jmp_addr_o  = '0;
    end
    endcase
end

always_comb begin
    next_w.pc = instr_i.pc;
    next_w.ir = instr_i.ir;

    case (dec_i.cw.alu_op1)
    OP1_RS1:  next_w.alu_op1 = rs1_w;
    OP1_IMMU: next_w.alu_op1 = dec_i.imm_u;
    default:  next_w.alu_op1 = '0;
    endcase

    case (dec_i.cw.alu_op2)
    OP2_RS2:  next_w.alu_op2 = rs2_w;
    OP2_IMMI: next_w.alu_op2 = dec_i.imm_i;
    OP2_IMMS: next_w.alu_op2 = dec_i.imm_s;
    OP2_PC:   next_w.alu_op2 = instr_i.pc;
    default:  next_w.alu_op2 = '0;
    endcase

    next_w.alu_mode = dec_i.cw.alu_mode;
    next_w.ma_mode  = dec_i.cw.ma_mode;
    next_w.ma_size  = dec_i.cw.ma_size;
    next_w.ma_data  = rs2_w;              // store data
    next_w.wb_src   = dec_i.cw.wb_src;
    next_w.wb_data  = instr_i.pc + 32'd4; // link address
    next_w.wb_valid = (dec_i.cw.wb_src != WB_SRC_X) && (dec_i.rd != '0);
    next_w.halt     = dec_i.cw.halt;
end

always_ff @(posedge clk_i) begin
    if (reset_i || hazard_w) begin
        id_ex_o <= NOP_ID_EX;
    end else begin
        id_ex_o <= next_w;
    end
end

// register-dependent jumps wait for their operands
assert property (@(posedge clk_i) disable iff (reset_i)
    (hazard_w && (dec_i.cw.pc_mode inside {PC_BRANCH, PC_JUMP_ABS})) |-> !jmp_valid_o)
    else $error("jump issued during a data hazard");

endmodule

`default_nettype wire

// ==== logic/id_stage.sv ====
`default_nettype none

module id_stage
    import rv_isa_pkg::*;
    import id_pipe_pkg::*;
(
    input  wire logic   clk_i,
    input  wire logic   reset_i,
    input  wire if_id_t if_id_i,
    input  wire fwd_t   ex_fwd_i,
    input  wire fwd_t   ma_fwd_i,
    input  wire fwd_t   wb_fwd_i,    // also the register file write port
    output      logic   ready_o,
    output      logic   jmp_valid_o,
    output      word_t  jmp_addr_o,
    output      id_ex_t id_ex_o
);

dec_t           dec_w;
src_req_t [1:0] src_w;
word_t    [1:0] rf_data_w;
word_t    [1:0] op_value_w;
logic     [1:0] hazard_w;

id_decoder u_decoder (
    .instr_i (if_id_i),
    .dec_o   (dec_w),
    .src_o   (src_w)
);

id_regfile u_regfile (
    .clk_i     (clk_i),
    .rd_addr_i ({src_w[1].addr, src_w[0].addr}),
    .rd_data_o (rf_data_w),
    .wr_i      (wb_fwd_i)
);

// one bypass unit per source register
for (genvar i = 0; i < 2; i++) begin : g_fwd
    id_operand_fwd u_fwd (
        .req_i     (src_w[i]),
        .rf_data_i (rf_data_w[i]),
        .ex_fwd_i  (ex_fwd_i),
        .ma_fwd_i  (ma_fwd_i),
        .wb_fwd_i  (wb_fwd_i),
        .value_o   (op_value_w[i]),
        .hazard_o  (hazard_w[i])
    );
end

id_issue u_issue (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .instr_i     (if_id_i),
    .dec_i       (dec_w),
    .op_value_i  (op_value_w),
    .hazard_i    (hazard_w),
    .ready_o     (ready_o),
    .jmp_valid_o (jmp_valid_o),
    .jmp_addr_o  (jmp_addr_o),
    .id_ex_o     (id_ex_o)
);

endmodule

`default_nettype wire

// ==== tests/id_stage_tests.svh ====
`ifndef ID_STAGE_TESTS_SVH
`define ID_STAGE_TESTS_SVH

// instruction encoders, field order as in the base ISA
function automatic word_t itype(input opcode_t op, input regaddr_t rd, input logic [2:0] f3,
                                input regaddr_t rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic word_t rtype(input logic [6:0] f7, input regaddr_t rs2, input regaddr_t rs1,
                                input logic [2:0] f3, input regaddr_t rd);
    return {f7, rs2, rs1, f3, rd, OP};
endfunction

function automatic word_t stype(input logic [2:0] f3, input regaddr_t rs1, input regaddr_t rs2,
                                input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
endfunction

function automatic word_t btype(input logic [2:0] f3, input regaddr_t rs1, input regaddr_t rs2,
                                input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
endfunction

function automatic word_t jtype(input regaddr_t rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
endfunction

// operand as the bypass rules give it, youngest producer first
function automatic word_t source_value(input regaddr_t a);
    if (ex_fwd.valid && ex_fwd.addr == a) return ex_fwd.data;
    if (ma_fwd.valid && ma_fwd.addr == a) return ma_fwd.data;
    if (wb_fwd.valid && wb_fwd.addr == a) return wb_fwd.data;
    return regs_m[a];
endfunction

function automatic id_ex_t plain_result(input word_t pc, input word_t ir);
    id_ex_t r;
    r          = '0;
    r.pc       = pc;
    r.ir       = ir;
    r.alu_mode = ALU_ADD;
    r.ma_mode  = MA_X;
    r.wb_src   = WB_SRC_X;
    r.ma_data  = source_value(ir[24:20]); // rs2 field
    r.wb_data  = pc + 32'd4;
    return r;
endfunction

function automatic id_ex_t alu_result(input word_t pc, input word_t ir, input word_t op1,
                                      input word_t op2, input alu_mode_t mode);
    id_ex_t r;
    r          = plain_result(pc, ir);
    r.alu_op1  = op1;
    r.alu_op2  = op2;
    r.alu_mode = mode;
    r.wb_src   = WB_SRC_ALU;
    r.wb_valid = (ir[11:7] != 5'd0);
    return r;
endfunction

function automatic logic branch_taken(input logic [2:0] f3, input word_t a, input word_t b);
    case (f3)
    F3_BEQ:  return a == b;
    F3_BNE:  return a != b;
    F3_BLT:  return $signed(a) < $signed(b);
    F3_BGE:  return $signed(a) >= $signed(b);
    F3_BLTU: return a < b;
    default: return a >= b;
    endcase
endfunction

task automatic reset_behavior();
    confirm_bubble();
    present(`RV_NOP_PC, `RV_NOP_IR);
    check_flag("ready_o", 1'b1, ready);
    check_flag("jmp_valid_o", 1'b0, jmp_valid);
    next_cycle();
endtask

task automatic alu_decode();
    word_t ir;
    for (int r = 1; r < `RV_NUM_REGS; r++) begin
        write_reg(regaddr_t'(r), $random(seed));
    end
    ir = itype(OP_IMM, 5'd5, 3'b000, 5'd3, 12'hff9); // addi x5, x3, -7
    decode_once(32'h1000, ir, alu_result(32'h1000, ir, regs_m[3], 32'hffff_fff9, ALU_ADD));
    ir = rtype(7'b000_0000, 5'd2, 5'd1, 3'b000, 5'd6);
    decode_once(32'h1004, ir, alu_result(32'h1004, ir, regs_m[1], regs_m[2], ALU_ADD));
    ir = rtype(7'b010_0000, 5'd5, 5'd4, 3'b000, 5'd7); // sub
    decode_once(32'h1008, ir, alu_result(32'h1008, ir, regs_m[4], regs_m[5], ALU_SUB));
    ir = {20'h12345, 5'd8, OP_LUI};
    decode_once(32'h100c, ir, alu_result(32'h100c, ir, 32'h1234_5000, '0, ALU_ADD));
    ir = itype(OP_IMM, 5'd0, 3'b000, 5'd1, 12'h001); // rd x0, no write
    decode_once(32'h1010, ir, alu_result(32'h1010, ir, regs_m[1], 32'd1, ALU_ADD));
endtask

task automatic bypass_priority();
    word_t ir;
    word_t d_ex;
    word_t d_ma;
    word_t d_wb;
    ir     = rtype(7'b000_0000, 5'd10, 5'd10, 3'b000, 5'd9); // add x9, x10, x10
    d_ex   = $random(seed);
    d_ma   = $random(seed);
    d_wb   = $random(seed);
    ex_fwd = bundle(5'd10, d_ex, 1'b1);
    ma_fwd = bundle(5'd10, d_ma, 1'b1);
    wb_fwd = bundle(5'd10, d_wb, 1'b1);
    decode_once(32'h2000, ir, alu_result(32'h2000, ir, d_ex, d_ex, ALU_ADD));
    ex_fwd = '0;
    decode_once(32'h2004, ir, alu_result(32'h2004, ir, d_ma, d_ma, ALU_ADD));
    ma_fwd = '0;
    decode_once(32'h2008, ir, alu_result(32'h2008, ir, d_wb, d_wb, ALU_ADD));
    wb_fwd = '0; // x10 now holds d_wb in the register file
    decode_once(32'h200c, ir, alu_result(32'h200c, ir, d_wb, d_wb, ALU_ADD));
endtask

task automatic hazard_stall();
    word_t  ir;
    id_ex_t exp;
    ex_fwd = bundle(5'd3, $random(seed), 1'b0);
    present(32'h3000, rtype(7'b000_0000, 5'd4, 5'd3, 3'b000, 5'd12));
    check_flag("ready_o", 1'b0, ready);
    next_cycle();
    confirm_bubble();
    present(32'h3004, itype(OP_JALR, 5'd1, 3'b000, 5'd3, 12'h008));
    check_flag("ready_o", 1'b0, ready);
    check_flag("jmp_valid_o", 1'b0, jmp_valid);
    next_cycle();
    confirm_bubble();
    ex_fwd = '0;
    ma_fwd = bundle(5'd4, $random(seed), 1'b0);
    ir     = btype(F3_BEQ, 5'd4, 5'd4, 13'h0010); // always taken once operands arrive
    present(32'h3008, ir);
    check_flag("ready_o", 1'b0, ready);
    check_flag("jmp_valid_o", 1'b0, jmp_valid);
    next_cycle();
    confirm_bubble();
    ma_fwd.ready = 1'b1;
    wait_ready(4);
    check_flag("jmp_valid_o", 1'b1, jmp_valid);
    compare_word("jmp_addr_o", 32'h3018, jmp_addr);
    exp = plain_result(32'h3008, ir);
    next_cycle();
    match_id_ex(exp, id_ex);
    ma_fwd = '0;
endtask

task automatic control_flow();
    word_t       pc;
    word_t       ir;
    word_t       a;
    word_t       b;
    logic [12:0] boff;
    logic [20:0] joff;
    logic [11:0] imm;
    logic [2:0]  f3;
    id_ex_t      exp;
    for (int k = 0; k < 12; k++) begin
        f3   = (k < 4) ? 3'(k / 2) : 3'(k / 2 + 2); // two cases per condition
        a    = $random(seed);
        b    = k[0] ? word_t'($random(seed)) : a;
        write_reg(5'd13, a);
        write_reg(5'd14, b);
        pc   = word_t'($random(seed)) & 32'hffff_fffc;
        boff = 13'($random(seed)) & 13'h1ffe;
        ir   = btype(f3, 5'd13, 5'd14, boff);
        exp  = plain_result(pc, ir);
        present(pc, ir);
        check_flag("jmp_valid_o", branch_taken(f3, a, b), jmp_valid);
        compare_word("jmp_addr_o", pc + {{19{boff[12]}}, boff}, jmp_addr);
        next_cycle();
        match_id_ex(exp, id_ex);
    end
    pc   = 32'h4000;
    joff = 21'($random(seed)) & 21'h1f_fffe;
    ir   = jtype(5'd1, joff);
    exp  = plain_result(pc, ir);
    exp.wb_src   = WB_SRC_PC4;
    exp.wb_valid = 1'b1;
    present(pc, ir);
    check_flag("jmp_valid_o", 1'b1, jmp_valid);
    compare_word("jmp_addr_o", pc + {{11{joff[20]}}, joff}, jmp_addr);
    next_cycle();
    match_id_ex(exp, id_ex);
    imm  = 12'($random(seed));
    ir   = itype(OP_JALR, 5'd2, 3'b000, 5'd13, imm);
    exp  = plain_result(pc, ir);
    exp.wb_src   = WB_SRC_PC4;
    exp.wb_valid = 1'b1;
    present(pc, ir);
    check_flag("jmp_valid_o", 1'b1, jmp_valid);
    compare_word("jmp_addr_o", regs_m[13] + {{20{imm[11]}}, imm}, jmp_addr);
    next_cycle();
    match_id_ex(exp, id_ex);
endtask

task automatic memory_and_halt();
    word_t       ir;
    logic [11:0] imm;
    id_ex_t      exp;
    imm = 12'($random(seed));
    ir  = stype(3'b001, 5'd13, 5'd14, imm); // sh
    exp = plain_result(32'h5000, ir);
    exp.alu_op1 = regs_m[13];
    exp.alu_op2 = {{20{imm[11]}}, imm};
    exp.ma_mode = MA_STORE;
    decode_once(32'h5000, ir, exp);
    compare_word("id_ex_o.ma_size", 32'd1, word_t'(id_ex.ma_size));
    ir  = itype(OP_LOAD, 5'd15, 3'b100, 5'd13, imm); // lbu
    exp = plain_result(32'h5004, ir);
    exp.alu_op1  = regs_m[13];
    exp.alu_op2  = {{20{imm[11]}}, imm};
    exp.ma_mode  = MA_LOAD;
    exp.wb_src   = WB_SRC_MEM;
    exp.wb_valid = 1'b1;
    decode_once(32'h5004, ir, exp);
    compare_word("id_ex_o.ma_size", 32'd4, word_t'(id_ex.ma_size));
    exp = plain_result(32'h5008, 32'hffff_ffff); // unknown opcode
    exp.halt = 1'b1;
    decode_once(32'h5008, 32'hffff_ffff, exp);
    exp = plain_result(32'h500c, 32'h0000_0073); // ecall
    exp.halt = 1'b1;
    decode_once(32'h500c, 32'h0000_0073, exp);
endtask

`endif

// ==== tests/id_stage_tb.sv ====
`default_nettype none

`include "rv_macros.svh"

module id_stage_tb
    import rv_isa_pkg::*;
    import id_pipe_pkg::*;
();

localparam int CLK_PERIOD   = 8;
localparam int SETTLE       = CLK_PERIOD / 4;
localparam int RESET_CYCLES = 16;
localparam int TEST_CYCLES  = 100; // directed tests below take about 90
localparam int SLACK_CYCLES = 50;

logic   clk_i;
logic   reset_i;
if_id_t if_id;
fwd_t   ex_fwd;
fwd_t   ma_fwd;
fwd_t   wb_fwd;
logic   ready;
logic   jmp_valid;
word_t  jmp_addr;
id_ex_t id_ex;

integer seed;
word_t  regs_m [`RV_NUM_REGS]; // expected register contents

id_stage DUT (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .if_id_i     (if_id),
    .ex_fwd_i    (ex_fwd),
    .ma_fwd_i    (ma_fwd),
    .wb_fwd_i    (wb_fwd),
    .ready_o     (ready),
    .jmp_valid_o (jmp_valid),
    .jmp_addr_o  (jmp_addr),
    .id_ex_o     (id_ex)
);

initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
end

// watchdog
initial begin
    #((RESET_CYCLES + TEST_CYCLES + SLACK_CYCLES) * CLK_PERIOD);
    $display("timeout: the directed tests did not finish in time");
    $display("Result: FAILED");
    $fatal(1, "watchdog expired");
end

task automatic abort_run(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "stopping at the first error");
endtask

task automatic compare_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
        abort_run($sformatf("error at %0t: %s expected %h, got %h", $time, name, exp, act));
    end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        abort_run($sformatf("error at %0t: %s expected %b, got %b", $time, name, exp, act));
    end
endtask

// every field except ma_size, which only loads and stores define
task automatic match_id_ex(input id_ex_t exp, input id_ex_t act);
    compare_word("id_ex_o.pc", exp.pc, act.pc);
    compare_word("id_ex_o.ir", exp.ir, act.ir);
    compare_word("id_ex_o.alu_op1", exp.alu_op1, act.alu_op1);
    compare_word("id_ex_o.alu_op2", exp.alu_op2, act.alu_op2);
    compare_word("id_ex_o.alu_mode", word_t'(exp.alu_mode), word_t'(act.alu_mode));
    compare_word("id_ex_o.ma_mode", word_t'(exp.ma_mode), word_t'(act.ma_mode));
    compare_word("id_ex_o.ma_data", exp.ma_data, act.ma_data);
    compare_word("id_ex_o.wb_src", word_t'(exp.wb_src), word_t'(act.wb_src));
    compare_word("id_ex_o.wb_data", exp.wb_data, act.wb_data);
    check_flag("id_ex_o.wb_valid", exp.wb_valid, act.wb_valid);
    check_flag("id_ex_o.halt", exp.halt, act.halt);
endtask

task automatic confirm_bubble();
    compare_word("id_ex_o.pc", `RV_NOP_PC, id_ex.pc);
    compare_word("id_ex_o.ir", `RV_NOP_IR, id_ex.ir);
    compare_word("id_ex_o.ma_mode", word_t'(MA_X), word_t'(id_ex.ma_mode));
    check_flag("id_ex_o.wb_valid", 1'b0, id_ex.wb_valid);
    check_flag("id_ex_o.halt", 1'b0, id_ex.halt);
endtask

// called at a falling edge, returns once the combinational outputs settled
task automatic present(input word_t pc, input word_t ir);
    if_id = '{pc: pc, ir: ir};
    #(SETTLE);
endtask

task automatic next_cycle();
    @(posedge clk_i);
    if (wb_fwd.valid) begin
        regs_m[wb_fwd.addr] = wb_fwd.data;
    end
    @(negedge clk_i);
endtask

function automatic fwd_t bundle(input regaddr_t a, input word_t d, input logic rdy);
    return '{valid: 1'b1, addr: a, data: d, ready: rdy};
endfunction

task automatic write_reg(input regaddr_t a, input word_t d);
    wb_fwd = bundle(a, d, 1'b1);
    next_cycle();
    wb_fwd = '0;
endtask

// fetch holds its word until the stage takes it
task automatic wait_ready(input int limit);
    int n;
    n = 0;
    #(SETTLE);
    while (!ready && n < limit) begin
        next_cycle();
        #(SETTLE);
        n++;
    end
    if (!ready) begin
        abort_run("ready_o stayed low after the producing stage became ready");
    end
endtask

task automatic decode_once(input word_t pc, input word_t ir, input id_ex_t exp);
    present(pc, ir);
    check_flag("ready_o", 1'b1, ready);
    next_cycle();
    match_id_ex(exp, id_ex);
endtask

`include "id_stage_tests.svh"

initial begin
    seed    = 32'h706a_c0c0;
    reset_i = 1'b1;
    if_id   = '{pc: `RV_NOP_PC, ir: `RV_NOP_IR};
    ex_fwd  = '0;
    ma_fwd  = '0;
    wb_fwd  = '0;
    for (int r = 0; r < `RV_NUM_REGS; r++) begin
        regs_m[r] = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    reset_behavior();
    alu_decode();
    bypass_priority();
    hazard_stall();
    control_flow();
    memory_and_halt();

    $display("Result: PASSED");
    $finish;
end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+logic
+incdir+tests
logic/rv_isa_pkg.sv
logic/id_pipe_pkg.sv
logic/id_decoder.sv
logic/id_regfile.sv
logic/id_operand_fwd.sv
logic/id_issue.sv
logic/id_stage.sv
tests/id_stage_tb.sv

// ==== Makefile ====
OBJ_DIR = obj_dir

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f compile.f \
		--top-module id_stage_tb -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/Vid_stage_tb

clean:
	rm -rf $(OBJ_DIR)
